// ==== source/icache_defs.svh ====
// cache geometry and refill credit macros, included by the package and the cache RTL
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// tag bits compared on a read
`define ICACHE_TAG_WIDTH 4

// instruction words held in the cache
`define ICACHE_ENTRIES 32

// words per line, power of two
`define ICACHE_BLOCK_WORDS 4

// fill FIFO depth, also the sender's starting credit count
`define REFILL_CREDITS 4

`define ICACHE_LINES (`ICACHE_ENTRIES / `ICACHE_BLOCK_WORDS)
`define ICACHE_INDEX_WIDTH $clog2(`ICACHE_LINES)
`define ICACHE_OFFSET_WIDTH $clog2(`ICACHE_BLOCK_WORDS)

// word-address PC covers tag, line index and block offset
`define ICACHE_PC_WIDTH (`ICACHE_TAG_WIDTH + $clog2(`ICACHE_ENTRIES))

`endif

// ==== source/icache_pkg.sv ====
// shared fetch-cache types and RV32 immediate helpers, imported by the RTL and the testbench
`include "icache_defs.svh"

package icache_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [`ICACHE_PC_WIDTH-1:0] pc_t;
  typedef logic [`ICACHE_PC_WIDTH+1:0] byte_pc_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_WIDTH-1:0] line_idx_t;
  typedef logic [`ICACHE_OFFSET_WIDTH-1:0] blk_off_t;

  // byte immediates of B and J formats, bit 0 always zero
  typedef logic [12:0] imm13_t;
  typedef logic [20:0] imm21_t;

  // only the opcodes that need target math
  typedef enum logic [6:0] {
    OP_OTHER  = 7'b0000000,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111
  } rv_opcode_e;

  typedef struct packed {
    pc_t    pc;
    instr_t instr;
  } fill_word_s;

  typedef struct packed {
    instr_t instr;
    logic   lower_sign;
    logic   lower_cout;
  } predecoded_s;

  typedef struct packed {
    tag_t                             tag;
    logic [`ICACHE_BLOCK_WORDS-1:0]   lower_sign;
    logic [`ICACHE_BLOCK_WORDS-1:0]   lower_cout;
    instr_t [`ICACHE_BLOCK_WORDS-1:0] instr;
  } icache_line_s;

  function automatic rv_opcode_e classify_op(instr_t instr);
    rv_opcode_e op;
    case (instr[6:0])
      OP_BRANCH: op = OP_BRANCH;
      OP_JAL:    op = OP_JAL;
      OP_JALR:   op = OP_JALR;
      default:   op = OP_OTHER;
    endcase
    return op;
  endfunction

  function automatic imm13_t bimm13(instr_t instr);
    return {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  function automatic imm21_t jimm21(instr_t instr);
    return {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

endpackage

// ==== source/icache_predecode.sv ====
// fill-path predecode that folds the low PC bits into JAL and branch immediates
`timescale 1ns/100ps

module icache_predecode
  import icache_pkg::*;
(
  input  fill_word_s  fill_i,
  output predecoded_s predec_o
);

  rv_opcode_e op;
  imm13_t     br_imm;
  imm21_t     jal_imm;
  byte_pc_t   pc_byte;
  imm13_t     pc_low;
  imm13_t     br_sum;
  imm13_t     jal_sum;
  logic       br_cout;
  logic       jal_cout;
  instr_t     instr_inj;

  assign op      = classify_op(fill_i.instr);
  assign br_imm  = bimm13(fill_i.instr);
  assign jal_imm = jimm21(fill_i.instr);

  // low 13 bits of the byte address, zero extended if the PC is narrower
  assign pc_byte = {fill_i.pc, 2'b00};
  assign pc_low  = imm13_t'(pc_byte);

  // unsigned low adds, carry goes to the read-side high add
  assign {br_cout, br_sum}   = {1'b0, br_imm} + {1'b0, pc_low};
  assign {jal_cout, jal_sum} = {1'b0, jal_imm[12:0]} + {1'b0, pc_low};

  always_comb begin
    instr_inj           = fill_i.instr;
    predec_o.lower_sign = 1'b0;
    predec_o.lower_cout = 1'b0;
    case (op)
      OP_BRANCH: begin
        // sum[12:1] back into imm[12|11|10:5|4:1]
        instr_inj[31]       = br_sum[12];
        instr_inj[7]        = br_sum[11];
        instr_inj[30:25]    = br_sum[10:5];
        instr_inj[11:8]     = br_sum[4:1];
        predec_o.lower_sign = br_imm[12];
        predec_o.lower_cout = br_cout;
      end
      OP_JAL: begin
        // only imm[12:1] replaced, imm[20:13] stays for the high add
        instr_inj[12]       = jal_sum[12];
        instr_inj[20]       = jal_sum[11];
        instr_inj[30:21]    = jal_sum[10:1];
        predec_o.lower_cout = jal_cout;
      end
      default: begin
      end
    endcase
    predec_o.instr = instr_inj;
  end

endmodule

// ==== source/icache_mem.sv ====
// single-port line RAM of the instruction cache, output holds between reads
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_mem
  import icache_pkg::*;
(
  input  logic         clk_i,
  input  logic         v_i,
  input  logic         w_i,
  input  line_idx_t    addr_i,
  input  icache_line_s data_i,
  output icache_line_s data_o
);

  icache_line_s mem_q [`ICACHE_LINES];

  // a write does not update the read port
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        mem_q[addr_i] <= data_i;
      end else begin
        data_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== source/icache.sv ====
// instruction cache with line fill buffer, target completion and miss detection
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       network_reset_i,
  input  logic       fill_v_i,
  input  fill_word_s fill_i,
  input  logic       core_v_i,
  input  pc_t        core_pc_i,
  input  logic       read_pc_plus4_i,
  input  pc_t        jalr_prediction_i,
  input  logic       flush_i,
  output instr_t     instr_o,
  output pc_t        pc_r_o,
  output pc_t        target_o,
  output logic       miss_o,
  output logic       pred_taken_o,
  output logic       flush_r_o
);

  localparam int PC_W   = `ICACHE_PC_WIDTH;
  localparam int OFF_W  = `ICACHE_OFFSET_WIDTH;
  localparam int LOW_W  = 13;
  // high part of the byte target, at least one bit wide
  localparam int HIGH_W = (PC_W + 2 > LOW_W) ? PC_W + 2 - LOW_W : 1;
  localparam int EXT_W  = LOW_W + HIGH_W;

  predecoded_s  predec;
  icache_line_s line_in;
  icache_line_s line_out;
  tag_t         w_tag;
  line_idx_t    w_idx;
  tag_t         w_tag_r;
  line_idx_t    w_idx_r;
  blk_off_t     write_count_r;
  logic         last_word;
  logic         write_en_r;
  logic [`ICACHE_BLOCK_WORDS-1:0] sign_buf_r;
  logic [`ICACHE_BLOCK_WORDS-1:0] cout_buf_r;
  instr_t [`ICACHE_BLOCK_WORDS-1:0] instr_buf_r;

  logic         read_acc;
  logic         mem_v;
  line_idx_t    mem_addr;
  pc_t          pc_r;
  logic         flush_r;
  blk_off_t     r_off;
  tag_t         r_tag;

  instr_t       instr_out;
  logic         sign_out;
  logic         cout_out;
  rv_opcode_e   op_out;
  imm21_t       jal_imm_out;
  logic [EXT_W-1:0]  pc_ext;
  logic [HIGH_W-1:0] pc_high;
  logic [HIGH_W-1:0] br_high;
  logic [HIGH_W-1:0] jal_high;
  logic [HIGH_W-1:0] jal_upper;
  logic [EXT_W-1:0]  br_target;
  logic [EXT_W-1:0]  jal_target;

  icache_predecode i_predecode (
    .fill_i   (fill_i),
    .predec_o (predec)
  );

  assign {w_tag, w_idx} = fill_i.pc[PC_W-1:OFF_W];
  assign last_word      = write_count_r == blk_off_t'(`ICACHE_BLOCK_WORDS - 1);

  // words arrive in offset order, so a counter picks the slot
  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      write_count_r <= '0;
      write_en_r    <= 1'b0;
    end else begin
      if (fill_v_i) begin
        write_count_r <= write_count_r + 1'b1;
      end
      write_en_r <= fill_v_i & last_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      sign_buf_r[write_count_r]  <= predec.lower_sign;
      cout_buf_r[write_count_r]  <= predec.lower_cout;
      instr_buf_r[write_count_r] <= predec.instr;
    end
    if (fill_v_i & last_word) begin
      w_tag_r <= w_tag;
      w_idx_r <= w_idx;
    end
  end

  assign line_in = '{
    tag        : w_tag_r,
    lower_sign : sign_buf_r,
    lower_cout : cout_buf_r,
    instr      : instr_buf_r
  };

  assign read_acc = core_v_i & ~fill_v_i;

  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      pc_r    <= '0;
      flush_r <= 1'b0;
    end else if (read_acc) begin
      pc_r    <= core_pc_i;
      flush_r <= 1'b0;
    end else begin
      flush_r <= flush_i;
    end
  end

  assign r_off = pc_r[OFF_W-1:0];
  assign r_tag = pc_r[PC_W-1 -: `ICACHE_TAG_WIDTH];

  // skip the array read when the next word sits in the line already held
  assign mem_v    = write_en_r | (read_acc & (&r_off | ~read_pc_plus4_i));
  assign mem_addr = write_en_r ? w_idx_r : core_pc_i[OFF_W +: `ICACHE_INDEX_WIDTH];

  icache_mem i_mem (
    .clk_i  (clk_i),
    .v_i    (mem_v),
    .w_i    (write_en_r),
    .addr_i (mem_addr),
    .data_i (line_in),
    .data_o (line_out)
  );

  assign instr_out   = line_out.instr[r_off];
  assign sign_out    = line_out.lower_sign[r_off];
  assign cout_out    = line_out.lower_cout[r_off];
  assign op_out      = classify_op(instr_out);
  assign jal_imm_out = jimm21(instr_out);

  // high part add on the byte address
  assign pc_ext    = EXT_W'({pc_r, 2'b00});
  assign pc_high   = pc_ext[LOW_W +: HIGH_W];
  assign jal_upper = HIGH_W'(signed'(jal_imm_out[20:13]));
  assign br_high   = pc_high + {HIGH_W{sign_out}} + HIGH_W'(cout_out);
  assign jal_high  = pc_high + jal_upper + HIGH_W'(cout_out);

  assign br_target  = {br_high, bimm13(instr_out)};
  assign jal_target = {jal_high, jal_imm_out[12:0]};

  always_comb begin
    case (op_out)
      OP_JAL:  target_o = jal_target[2 +: PC_W];
      OP_JALR: target_o = jalr_prediction_i;
      default: target_o = br_target[2 +: PC_W];
    endcase
  end

  assign instr_o      = instr_out;
  assign pc_r_o       = pc_r;
  assign miss_o       = line_out.tag != r_tag;
  // backward branch predicted taken
  assign pred_taken_o = sign_out;
  assign flush_r_o    = flush_r;

endmodule

// ==== source/icache_refill.sv ====
// network fill receiver, credit-based FIFO that only drains while the core is not reading
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_refill
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       network_reset_i,
  input  logic       net_v_i,
  input  fill_word_s net_fill_i,
  output logic       net_credit_o,
  input  logic       core_v_i,
  output logic       fill_v_o,
  output fill_word_s fill_o
);

  localparam int DEPTH = `REFILL_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  fill_word_s       fifo_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0]   count_r;
  logic             pop;
  logic             credit_r;

  // sender holds a credit per free slot, so a push never overflows
  assign pop = (count_r != '0) & ~core_v_i;

  always_ff @(posedge clk_i) begin
    if (net_v_i) begin
      fifo_q[wr_ptr_r] <= net_fill_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      credit_r <= 1'b0;
    end else begin
      if (net_v_i) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({net_v_i, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
      // credit returned the cycle after the pop
      credit_r <= pop;
    end
  end

  assign net_credit_o = credit_r;
  assign fill_v_o     = pop;
  assign fill_o       = fifo_q[rd_ptr_r];

endmodule

// ==== source/fetch_top.sv ====
// fetch memory top level joining the network refill unit to the instruction cache
`timescale 1ns/100ps

module fetch_top
  import icache_pkg::*;
(
  input  logic       clk_i,
  input  logic       network_reset_i,
  input  logic       net_v_i,
  input  fill_word_s net_fill_i,
  output logic       net_credit_o,
  input  logic       core_v_i,
  input  pc_t        core_pc_i,
  input  logic       read_pc_plus4_i,
  input  pc_t        jalr_prediction_i,
  input  logic       flush_i,
  output instr_t     instr_o,
  output pc_t        pc_r_o,
  output pc_t        target_o,
  output logic       miss_o,
  output logic       pred_taken_o,
  output logic       flush_r_o
);

  logic       fill_v;
  fill_word_s fill;

  icache_refill i_refill (
    .clk_i           (clk_i),
    .network_reset_i (network_reset_i),
    .net_v_i         (net_v_i),
    .net_fill_i      (net_fill_i),
    .net_credit_o    (net_credit_o),
    .core_v_i        (core_v_i),
    .fill_v_o        (fill_v),
    .fill_o          (fill)
  );

  icache i_icache (
    .clk_i             (clk_i),
    .network_reset_i   (network_reset_i),
    .fill_v_i          (fill_v),
    .fill_i            (fill),
    .core_v_i          (core_v_i),
    .core_pc_i         (core_pc_i),
    .read_pc_plus4_i   (read_pc_plus4_i),
    .jalr_prediction_i (jalr_prediction_i),
    .flush_i           (flush_i),
    .instr_o           (instr_o),
    .pc_r_o            (pc_r_o),
    .target_o          (target_o),
    .miss_o            (miss_o),
    .pred_taken_o      (pred_taken_o),
    .flush_r_o         (flush_r_o)
  );

endmodule

// ==== bench/tb_fetch_top.sv ====
// directed testbench for the fetch memory, drives network fills and core reads and checks results
`timescale 1ns/100ps
`include "icache_defs.svh"

module tb_fetch_top
  import icache_pkg::*;
();

  // the tests run for roughly 200 cycles
  // limit leaves wide headroom for throttled fills
  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk_i;
  logic       network_reset_i;
  logic       net_v_i;
  fill_word_s net_fill_i;
  logic       net_credit_o;
  logic       core_v_i;
  pc_t        core_pc_i;
  logic       read_pc_plus4_i;
  pc_t        jalr_prediction_i;
  logic       flush_i;
  instr_t     instr_o;
  pc_t        pc_r_o;
  pc_t        target_o;
  logic       miss_o;
  logic       pred_taken_o;
  logic       flush_r_o;

  integer seed = 95;
  int     cycle_count = 0;
  int     credits_sent = 0;
  int     credits_returned = 0;
  logic   throttle = 1'b0;
  instr_t model_mem [2**`ICACHE_PC_WIDTH];

  fetch_top i_fetch_top (
    .clk_i             (clk_i),
    .network_reset_i   (network_reset_i),
    .net_v_i           (net_v_i),
    .net_fill_i        (net_fill_i),
    .net_credit_o      (net_credit_o),
    .core_v_i          (core_v_i),
    .core_pc_i         (core_pc_i),
    .read_pc_plus4_i   (read_pc_plus4_i),
    .jalr_prediction_i (jalr_prediction_i),
    .flush_i           (flush_i),
    .instr_o           (instr_o),
    .pc_r_o            (pc_r_o),
    .target_o          (target_o),
    .miss_o            (miss_o),
    .pred_taken_o      (pred_taken_o),
    .flush_r_o         (flush_r_o)
  );

  always #2 clk_i = ~clk_i;

  // credit pulses counted one edge late
  always @(posedge clk_i) begin
    if (!network_reset_i && net_credit_o === 1'b1) begin
      credits_returned <= credits_returned + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_pc(input string name, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  function automatic pc_t make_pc(tag_t tag, line_idx_t idx, blk_off_t off);
    return {tag, idx, off};
  endfunction

  // B-format encoding from a byte offset
  function automatic instr_t encode_branch(int imm);
    logic [12:0] b;
    b = imm[12:0];
    return {b[12], b[10:5], 5'd2, 5'd1, 3'b000, b[4:1], b[11], 7'b1100011};
  endfunction

  // J-format encoding from a byte offset
  function automatic instr_t encode_jal(int imm);
    logic [20:0] j;
    j = imm[20:0];
    return {j[20], j[10:1], j[11], j[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic instr_t encode_other();
    logic [31:0] r;
    r = $random(seed);
    return {r[31:7], 7'b0010011};
  endfunction

  // sends one word once a credit is held
  task automatic send_word(input pc_t pc);
    logic sent;
    sent = 1'b0;
    while (!sent) begin
      @(posedge clk_i);
      if (throttle && (($random(seed) & 1) != 0)) begin
        net_v_i <= 1'b0;
      end else if (credits_sent - credits_returned < `REFILL_CREDITS) begin
        net_v_i          <= 1'b1;
        net_fill_i.pc    <= pc;
        net_fill_i.instr <= model_mem[pc];
        credits_sent = credits_sent + 1;
        sent = 1'b1;
      end else begin
        net_v_i <= 1'b0;
      end
    end
  endtask

  task automatic send_line(input tag_t tag, input line_idx_t idx);
    for (int off = 0; off < `ICACHE_BLOCK_WORDS; off++) begin
      send_word(make_pc(tag, idx, blk_off_t'(off)));
    end
    @(posedge clk_i);
    net_v_i <= 1'b0;
  endtask

  // all credits back means the FIFO is empty
  // the line write then still needs a few cycles
  task automatic wait_drain();
    while (credits_returned != credits_sent) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
  endtask

  task automatic fill_line(input tag_t tag, input line_idx_t idx);
    send_line(tag, idx);
    wait_drain();
  endtask

  task automatic read_word(input pc_t pc, input logic plus4, input pc_t jalr);
    @(posedge clk_i);
    core_v_i          <= 1'b1;
    core_pc_i         <= pc;
    read_pc_plus4_i   <= plus4;
    jalr_prediction_i <= jalr;
    @(posedge clk_i);
    core_v_i        <= 1'b0;
    read_pc_plus4_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic expect_hit(input string name, input pc_t pc);
    check_instr(name, model_mem[pc], instr_o);
    check_pc(name, pc, pc_r_o);
    check_bit(name, 1'b0, miss_o);
  endtask

  task automatic refill_and_hit();
    pc_t pc;
    for (int i = 0; i < 4; i++) begin
      model_mem[make_pc(4'd1, 3'd0, blk_off_t'(i))] = encode_other();
      model_mem[make_pc(4'd3, 3'd1, blk_off_t'(i))] = encode_other();
    end
    fill_line(4'd1, 3'd0);
    // second line with random gaps on the network side
    throttle = 1'b1;
    fill_line(4'd3, 3'd1);
    throttle = 1'b0;
    for (int i = 0; i < 8; i++) begin
      pc = make_pc((i < 4) ? 4'd1 : 4'd3, (i < 4) ? 3'd0 : 3'd1, blk_off_t'(i));
      read_word(pc, 1'b0, '0);
      expect_hit("refill_hit", pc);
    end
  endtask

  task automatic predecoded_targets();
    int   kind [8];
    int   imm [8];
    pc_t  pc;
    pc_t  jalr;
    // kind 0 other, 1 branch, 2 jal, 3 jalr
    kind = '{1, 1, 2, 3, 2, 1, 2, 1};
    imm  = '{40, -200, -1000, 0, 2000, -4, 1048572, 4092};
    for (int i = 0; i < 8; i++) begin
      pc = make_pc((i < 4) ? 4'd5 : 4'd7, (i < 4) ? 3'd2 : 3'd5, blk_off_t'(i));
      case (kind[i])
        1:       model_mem[pc] = encode_branch(imm[i]);
        2:       model_mem[pc] = encode_jal(imm[i]);
        default: model_mem[pc] = {12'h000, 5'd1, 3'b000, 5'd0, 7'b1100111};
      endcase
    end
    fill_line(4'd5, 3'd2);
    fill_line(4'd7, 3'd5);
    for (int i = 0; i < 8; i++) begin
      pc   = make_pc((i < 4) ? 4'd5 : 4'd7, (i < 4) ? 3'd2 : 3'd5, blk_off_t'(i));
      jalr = pc ^ 9'h1a5;
      read_word(pc, 1'b0, jalr);
      check_pc("targets", pc, pc_r_o);
      check_bit("targets", 1'b0, miss_o);
      if (kind[i] == 3) begin
        check_pc("targets", jalr, target_o);
      end else begin
        check_pc("targets", pc_t'(int'(pc) + imm[i] / 4), target_o);
      end
      check_bit("targets", (kind[i] == 1) && (imm[i] < 0), pred_taken_o);
    end
  endtask

  task automatic tag_miss();
    read_word(make_pc(4'd6, 3'd2, 2'd1), 1'b0, '0);
    check_bit("miss", 1'b1, miss_o);
  endtask

  task automatic credit_backpressure();
    int  credits;
    pc_t pc;
    for (int i = 0; i < 4; i++) begin
      model_mem[make_pc(4'd2, 3'd3, blk_off_t'(i))] = encode_other();
    end
    @(posedge clk_i);
    core_v_i        <= 1'b1;
    core_pc_i       <= make_pc(4'd1, 3'd0, 2'd0);
    read_pc_plus4_i <= 1'b0;
    send_line(4'd2, 3'd3);
    repeat (6) begin
      @(negedge clk_i);
      check_bit("backpressure", 1'b0, net_credit_o);
    end
    @(posedge clk_i);
    core_v_i <= 1'b0;
    credits = 0;
    repeat (10) begin
      @(negedge clk_i);
      if (net_credit_o === 1'b1) begin
        credits++;
      end
    end
    if (credits != `REFILL_CREDITS) begin
      fail_run($sformatf("Mismatch in backpressure: expected %0d credits, actual %0d",
                         `REFILL_CREDITS, credits));
    end
    wait_drain();
    for (int i = 0; i < 4; i++) begin
      pc = make_pc(4'd2, 3'd3, blk_off_t'(i));
      read_word(pc, 1'b0, '0);
      expect_hit("backpressure", pc);
    end
  endtask

  task automatic hint_and_flush();
    pc_t pc;
    for (int i = 0; i < 4; i++) begin
      pc = make_pc(4'd3, 3'd1, blk_off_t'(i));
      read_word(pc, i != 0, '0);
      expect_hit("hint_flush", pc);
    end
    // pc+4 out of the last word must fetch the next line, which holds tag 5
    pc = make_pc(4'd3, 3'd2, 2'd0);
    read_word(pc, 1'b1, '0);
    check_pc("hint_flush", pc, pc_r_o);
    check_bit("hint_flush", 1'b1, miss_o);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_bit("hint_flush", 1'b1, flush_r_o);
    // flush_i stays high so only the read can clear the register
    read_word(make_pc(4'd1, 3'd0, 2'd2), 1'b0, '0);
    check_bit("hint_flush", 1'b0, flush_r_o);
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  initial begin
    clk_i             = 1'b0;
    network_reset_i   = 1'b1;
    net_v_i           = 1'b0;
    net_fill_i        = '0;
    core_v_i          = 1'b0;
    core_pc_i         = '0;
    read_pc_plus4_i   = 1'b0;
    jalr_prediction_i = '0;
    flush_i           = 1'b0;
    repeat (5) @(posedge clk_i);
    network_reset_i <= 1'b0;
    refill_and_hit();
    predecoded_targets();
    tag_miss();
    credit_backpressure();
    hint_and_flush();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+source
source/icache_pkg.sv
source/icache_predecode.sv
source/icache_mem.sv
source/icache.sv
source/icache_refill.sv
source/fetch_top.sv
bench/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/icache_pkg.sv
      - source/icache_predecode.sv
      - source/icache_mem.sv
      - source/icache.sv
      - source/icache_refill.sv
      - source/fetch_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_fetch_top.sv
